/* tb.f */
+incdir+include
source/vchess_pkg.sv
source/host_regs.sv
source/board_store.sv
source/status_sync.sv
source/xorshift32.sv
source/vchess_top.sv
tests/tb_vchess.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, exit status follows the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_vchess \
   -o sim_tb_vchess \
   && ./obj_dir/sim_tb_vchess \
   || { echo "simulation run did not complete cleanly"; exit 1; }
exit 0

/* tests/tb_vchess.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vchess_config.svh"

module tb_vchess;

   localparam int TIMEOUT_CYCLES = 50;

   // One row of the operation table
   typedef struct packed {
      logic                  write;
      vchess_pkg::reg_addr_t addr;
      vchess_pkg::reg_data_t wdata;
      vchess_pkg::reg_data_t expected;
   } op_t;

   logic                  c0_ddr4_ui_clk;
   logic                  arst_n;
   logic                  req;
   vchess_pkg::host_req_t host_req;
   logic                  ack;
   vchess_pkg::reg_data_t rdata;
   logic                  calib_complete_async;
   logic                  ddr4_rst_async;
   vchess_pkg::board_t    board;
   logic                  board_valid;

   op_t                   ops[$];
   vchess_pkg::board_t    model_board;     // Active board as the host expects it
   vchess_pkg::board_t    staging_model;
   vchess_pkg::reg_data_t rnd_model;
   int                    pulse_count;

   vchess_top UUT
     (
      .c0_ddr4_ui_clk       (c0_ddr4_ui_clk),
      .arst_n               (arst_n),
      .req                  (req),
      .host_req             (host_req),
      .ack                  (ack),
      .rdata                (rdata),
      .calib_complete_async (calib_complete_async),
      .ddr4_rst_async       (ddr4_rst_async),
      .board                (board),
      .board_valid          (board_valid));

   initial
      c0_ddr4_ui_clk = 1'b0;

   always #5 c0_ddr4_ui_clk = ~c0_ddr4_ui_clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic compare(input logic [255:0] actual, input logic [255:0] expected,
                          input string what);
      if (actual !== expected)
         abort_run($sformatf("Mismatch at %0t ns: %s, got %0h expected %0h",
                             $time, what, actual, expected));
   endtask

   // Standard opening setup, black codes are white codes plus 8
   function automatic vchess_pkg::board_t initial_board();
      vchess_pkg::piece_t order [8];
      vchess_pkg::board_t b;
      int                 f;
      order = '{`WHITE_ROOK, `WHITE_KNIT, `WHITE_BISH, `WHITE_QUEN,
                `WHITE_KING, `WHITE_BISH, `WHITE_KNIT, `WHITE_ROOK};
      b = '0;
      for (f = 0; f < 8; f++)
      begin
         b[f]      = order[f];
         b[8 + f]  = `WHITE_PAWN;
         b[48 + f] = `BLACK_PAWN;
         b[56 + f] = order[f] + 4'd8;
      end
      return b;
   endfunction

   function automatic vchess_pkg::reg_data_t xorshift_next(input vchess_pkg::reg_data_t s);
      vchess_pkg::reg_data_t x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic vchess_pkg::reg_addr_t square_addr(input int sq);
      return vchess_pkg::reg_addr_t'(`REG_SQUARE_BASE + sq);
   endfunction

   // Any legal code, empty included
   function automatic vchess_pkg::piece_t random_piece();
      int code;
      code = $urandom % 13;
      if (code > 6)
         code += 2;                                // Skip the unused codes 7 and 8
      return vchess_pkg::piece_t'(code);
   endfunction

   function automatic void add_write(input vchess_pkg::reg_addr_t addr, input int data);
      ops.push_back(op_t'{1'b1, addr, vchess_pkg::reg_data_t'(data), '0});
   endfunction

   function automatic void add_read(input vchess_pkg::reg_addr_t addr, input int expected);
      ops.push_back(op_t'{1'b0, addr, '0, vchess_pkg::reg_data_t'(expected)});
   endfunction

   // Full four-phase transfer, called and returning on a falling edge
   task automatic transfer(input logic write, input vchess_pkg::reg_addr_t addr,
                           input vchess_pkg::reg_data_t wdata,
                           output vchess_pkg::reg_data_t data);
      int wait_cycles;
      compare(ack, 1'b0, "ack low before new request");
      host_req = '{write, addr, wdata};
      req      = 1'b1;
      wait_cycles = 0;
      while (ack !== 1'b1)
      begin
         @(negedge c0_ddr4_ui_clk);
         wait_cycles++;
         if (wait_cycles > TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout at %0t ns: ack never rose for address %0h",
                                $time, addr));
      end
      data = rdata;
      req  = 1'b0;
      wait_cycles = 0;
      while (ack !== 1'b0)
      begin
         @(negedge c0_ddr4_ui_clk);
         wait_cycles++;
         if (wait_cycles > TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout at %0t ns: ack stayed high after req dropped",
                                $time));
      end
   endtask

   task automatic run_ops();
      vchess_pkg::reg_data_t data;
      foreach (ops[i])
      begin
         transfer(ops[i].write, ops[i].addr, ops[i].wdata, data);
         if (!ops[i].write)
            compare(data, ops[i].expected, $sformatf("read of address %0h", ops[i].addr));
      end
      ops.delete();
   endtask

   // Counts commit pulses and checks the board they carry
   always @(negedge c0_ddr4_ui_clk)
   begin
      if (arst_n && board_valid)
      begin
         pulse_count++;
         compare(board, model_board, "board while board_valid is high");
      end
   end

   initial
   begin
      int                    i;
      int                    pulses_before;
      vchess_pkg::square_t   sq;
      vchess_pkg::piece_t    pc;
      vchess_pkg::reg_data_t data;
      vchess_pkg::status_t   st;
      vchess_pkg::counter_t  last_count;
      void'($urandom(32'h983f_d93b));
      arst_n               = 1'b0;
      req                  = 1'b0;
      host_req             = '0;
      calib_complete_async = 1'b0;
      ddr4_rst_async       = 1'b0;
      pulse_count          = 0;
      model_board          = initial_board();
      staging_model        = model_board;
      rnd_model            = `XORSHIFT_SEED;
      repeat (2) @(negedge c0_ddr4_ui_clk);
      arst_n = 1'b1;
      @(negedge c0_ddr4_ui_clk);

      for (i = 0; i < `SQUARE_COUNT; i++)
         add_read(square_addr(i), model_board[i]);  // Opening position after reset
      run_ops();

      pulses_before = pulse_count;
      for (i = 0; i < 8; i++)
      begin
         sq = vchess_pkg::square_t'($urandom % `SQUARE_COUNT);
         pc = random_piece();
         staging_model[sq] = pc;
         add_write(square_addr(sq), pc);
      end
      add_write(`REG_LOAD, 1);
      model_board = staging_model;                  // Board expected from the commit
      run_ops();
      for (i = 0; i < `SQUARE_COUNT; i++)
         add_read(square_addr(i), model_board[i]);
      run_ops();
      compare(pulse_count, pulses_before + 1, "one valid pulse per commit");

      // Flag already high, staging changes stay hidden
      pulses_before = pulse_count;
      for (i = 24; i < 32; i++)
      begin
         pc = (staging_model[i] == `WHITE_QUEN) ? `WHITE_KING : `WHITE_QUEN;
         staging_model[i] = pc;
         add_write(square_addr(i), pc);
      end
      add_write(`REG_LOAD, 1);
      for (i = 24; i < 32; i++)
         add_read(square_addr(i), model_board[i]);
      add_read(`REG_LOAD, 1);
      run_ops();
      compare(pulse_count, pulses_before, "no pulse while load flag stays high");
      add_write(`REG_LOAD, 0);
      add_write(`REG_LOAD, 1);
      model_board = staging_model;
      run_ops();
      for (i = 0; i < `SQUARE_COUNT; i++)
         add_read(square_addr(i), model_board[i]);
      run_ops();
      compare(pulse_count, pulses_before + 1, "one pulse after load flag toggles");

      for (i = 0; i < 8; i++)
      begin
         add_read(`REG_RANDOM, rnd_model);
         rnd_model = xorshift_next(rnd_model);       // Read returns value, then steps
      end
      run_ops();

      last_count = '0;
      for (i = 0; i < 4; i++)
      begin
         calib_complete_async = i[0];
         ddr4_rst_async       = i[1];
         repeat (3) @(negedge c0_ddr4_ui_clk);       // Past the two sync stages
         transfer(1'b0, `REG_STATUS, '0, data);
         st = data;
         compare(st.calib_done, calib_complete_async, "status calibration bit");
         compare(st.mem_rst, ddr4_rst_async, "status memory reset bit");
         compare(st.reserved, 0, "status reserved bits");
         if (i > 0)
            compare(st.counter != last_count, 1'b1, "status counter advances");
         last_count = st.counter;
      end

      add_write(8'h10, 32'hdead_beef);              // Ignored
      add_read(8'h10, 0);
      add_read(8'h03, 0);
      add_read(8'h3f, 0);
      add_read(8'h80, 0);
      add_read(8'hff, 0);
      run_ops();

      @(negedge c0_ddr4_ui_clk);
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* source/vchess_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vchess_top
  (
   input  wire                       c0_ddr4_ui_clk,
   input  wire                       arst_n,
   input  wire                       req,
   input  wire vchess_pkg::host_req_t host_req,
   output logic                      ack,
   output vchess_pkg::reg_data_t     rdata,
   input  wire                       calib_complete_async,
   input  wire                       ddr4_rst_async,
   output vchess_pkg::board_t        board,
   output logic                      board_valid
   );

   logic                  sq_wr;
   vchess_pkg::square_t   sq_index;
   vchess_pkg::piece_t    sq_piece;
   logic                  load_flag;
   vchess_pkg::square_t   rd_index;
   vchess_pkg::piece_t    rd_piece;
   vchess_pkg::status_t   status;
   vchess_pkg::reg_data_t rnd_value;
   logic                  rnd_next;

   host_regs host_regs
     (
      .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
      .arst_n         (arst_n),
      .req            (req),
      .host_req       (host_req),
      .ack            (ack),
      .rdata          (rdata),
      .sq_wr          (sq_wr),
      .sq_index       (sq_index),
      .sq_piece       (sq_piece),
      .load_flag      (load_flag),
      .rd_index       (rd_index),
      .rd_piece       (rd_piece),
      .status         (status),
      .rnd_value      (rnd_value),
      .rnd_next       (rnd_next));

   board_store board_store
     (
      .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
      .arst_n         (arst_n),
      .sq_wr          (sq_wr),
      .sq_index       (sq_index),
      .sq_piece       (sq_piece),
      .load_flag      (load_flag),
      .rd_index       (rd_index),
      .rd_piece       (rd_piece),
      .board          (board),          // To the move generator
      .board_valid    (board_valid));

   status_sync status_sync
     (
      .c0_ddr4_ui_clk       (c0_ddr4_ui_clk),
      .arst_n               (arst_n),
      .calib_complete_async (calib_complete_async),
      .ddr4_rst_async       (ddr4_rst_async),
      .status               (status));

   xorshift32 xorshift32
     (
      .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
      .arst_n         (arst_n),
      .next           (rnd_next),
      .value          (rnd_value));

endmodule

`default_nettype wire

/* source/xorshift32.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vchess_config.svh"

module xorshift32
  (
   input  wire                  c0_ddr4_ui_clk,
   input  wire                  arst_n,
   input  wire                  next,
   output vchess_pkg::reg_data_t value
   );

   vchess_pkg::reg_data_t step_a;
   vchess_pkg::reg_data_t step_b;
   vchess_pkg::reg_data_t step_c;

   always_comb
   begin
      step_a = value ^ (value << 13);
      step_b = step_a ^ (step_a >> 17);
      step_c = step_b ^ (step_b << 5);
   end

   always_ff @(posedge c0_ddr4_ui_clk or negedge arst_n)
   begin
      if (!arst_n)
         value <= `XORSHIFT_SEED;
      else if (next)
         value <= step_c;                        // One step per host read
   end

   // Zero is a fixed point, the sequence could never leave it
   never_zero : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!arst_n)
      value != '0);

endmodule

`default_nettype wire

/* source/status_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vchess_config.svh"

module status_sync
  (
   input  wire                c0_ddr4_ui_clk,
   input  wire                arst_n,
   input  wire                calib_complete_async,
   input  wire                ddr4_rst_async,
   output vchess_pkg::status_t status
   );

   // Bit 1 memory reset, bit 0 calibration, both flops per bit
   logic [1:0]           sync_meta;   // First stage, may go metastable
   logic [1:0]           sync_out;
   vchess_pkg::counter_t counter;

   always_ff @(posedge c0_ddr4_ui_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sync_meta <= '0;
         sync_out  <= '0;
      end
      else
      begin
         sync_meta <= {ddr4_rst_async, calib_complete_async};
         sync_out  <= sync_meta;
      end
   end

   always_ff @(posedge c0_ddr4_ui_clk or negedge arst_n)
   begin
      if (!arst_n)
         counter <= '0;
      else
         counter <= counter + 1'b1;             // Free running, wraps
   end

   always_comb
   begin
      status.counter    = counter;
      status.reserved   = '0;
      status.mem_rst    = sync_out[1];
      status.calib_done = sync_out[0];
   end

endmodule

`default_nettype wire

/* source/board_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vchess_config.svh"

module board_store
  (
   input  wire                     c0_ddr4_ui_clk,
   input  wire                     arst_n,
   input  wire                     sq_wr,
   input  wire vchess_pkg::square_t sq_index,
   input  wire vchess_pkg::piece_t  sq_piece,
   input  wire                     load_flag,
   input  wire vchess_pkg::square_t rd_index,
   output vchess_pkg::piece_t      rd_piece,
   output vchess_pkg::board_t      board,
   output logic                    board_valid
   );

   vchess_pkg::board_t staging;
   logic               load_flag_d;
   logic               load_rise;

   // Back rank order rook, knight, bishop, queen, king, bishop, knight, rook
   function automatic vchess_pkg::piece_t back_rank(input int file, input logic black);
      case (file)
         0, 7:    back_rank = black ? `BLACK_ROOK : `WHITE_ROOK;
         1, 6:    back_rank = black ? `BLACK_KNIT : `WHITE_KNIT;
         2, 5:    back_rank = black ? `BLACK_BISH : `WHITE_BISH;
         3:       back_rank = black ? `BLACK_QUEN : `WHITE_QUEN;
         default: back_rank = black ? `BLACK_KING : `WHITE_KING;
      endcase
   endfunction

   function automatic vchess_pkg::board_t start_position();
      vchess_pkg::board_t b;
      int                 file;
      b = {`SQUARE_COUNT{`EMPTY_POSN}};
      for (file = 0; file < 8; file++)
      begin
         b[file]      = back_rank(file, 1'b0);    // Rank 1
         b[8 + file]  = `WHITE_PAWN;              // Rank 2
         b[48 + file] = `BLACK_PAWN;              // Rank 7
         b[56 + file] = back_rank(file, 1'b1);    // Rank 8
      end
      return b;
   endfunction

   assign load_rise = load_flag && !load_flag_d;
   assign rd_piece  = board[rd_index];            // Host reads the active board

   always_ff @(posedge c0_ddr4_ui_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         staging     <= start_position();
         board       <= start_position();
         load_flag_d <= 1'b0;
         board_valid <= 1'b0;
      end
      else
      begin
         load_flag_d <= load_flag;
         board_valid <= load_rise;
         if (sq_wr)
            staging[sq_index] <= sq_piece;
         if (load_rise)
            board <= staging;                     // Commit, valid pulses with it
      end
   end

   // A commit needs a fresh rise of the host load flag
   valid_single_cycle : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!arst_n)
      board_valid |=> !board_valid);

endmodule

`default_nettype wire

/* source/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vchess_config.svh"

module host_regs
  (
   input  wire                       c0_ddr4_ui_clk,
   input  wire                       arst_n,
   input  wire                       req,
   input  wire vchess_pkg::host_req_t host_req,
   output logic                      ack,
   output vchess_pkg::reg_data_t     rdata,
   output logic                      sq_wr,
   output vchess_pkg::square_t       sq_index,
   output vchess_pkg::piece_t        sq_piece,
   output logic                      load_flag,
   output vchess_pkg::square_t       rd_index,
   input  wire vchess_pkg::piece_t   rd_piece,
   input  wire vchess_pkg::status_t  status,
   input  wire vchess_pkg::reg_data_t rnd_value,
   output logic                      rnd_next
   );

   vchess_pkg::hs_state_t state;
   vchess_pkg::hs_state_t state_next;
   vchess_pkg::reg_data_t read_value;
   logic                  access;
   logic                  is_square;

   assign access    = (state == vchess_pkg::HS_ACK);
   assign ack       = (state == vchess_pkg::HS_WAIT_RELEASE);
   assign is_square = (host_req.addr & ~vchess_pkg::reg_addr_t'(`SQUARE_COUNT - 1))
                      == `REG_SQUARE_BASE;

   // Square port, low address bits pick the square
   assign sq_index = host_req.addr[$bits(vchess_pkg::square_t)-1:0];
   assign rd_index = host_req.addr[$bits(vchess_pkg::square_t)-1:0];
   assign sq_piece = host_req.data[`PIECE_WIDTH-1:0];
   assign sq_wr    = access && host_req.write && is_square;

   // Generator steps on the same edge that captures its value
   assign rnd_next = access && !host_req.write && (host_req.addr == `REG_RANDOM);

   always_comb
   begin
      state_next = state;
      case (state)
         vchess_pkg::HS_IDLE:
         begin
            if (req)
               state_next = vchess_pkg::HS_ACK;
         end
         vchess_pkg::HS_ACK:
            state_next = vchess_pkg::HS_WAIT_RELEASE;
         vchess_pkg::HS_WAIT_RELEASE:
         begin
            if (!req)
               state_next = vchess_pkg::HS_IDLE;
         end
         default:
            state_next = vchess_pkg::HS_IDLE;
      endcase
   end

   always_comb
   begin
      read_value = '0;                              // Unmapped reads return zero
      if (is_square)
         read_value = vchess_pkg::reg_data_t'(rd_piece);
      else
      begin
         case (host_req.addr)
            `REG_STATUS: read_value = vchess_pkg::reg_data_t'(status);
            `REG_RANDOM: read_value = rnd_value;
            `REG_LOAD:   read_value = vchess_pkg::reg_data_t'(load_flag);
            default:     read_value = '0;
         endcase
      end
   end

   always_ff @(posedge c0_ddr4_ui_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= vchess_pkg::HS_IDLE;
         load_flag <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (access && host_req.write && (host_req.addr == `REG_LOAD))
            load_flag <= host_req.data[0];          // Level, edge found downstream
      end
   end

   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (access && !host_req.write)
         rdata <= read_value;                       // Stable while ack is high
   end

   // Host must still be requesting on the edge where the slave answers
   ack_needs_req : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!arst_n)
      $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

/* source/vchess_pkg.sv */
`default_nettype none

`include "vchess_config.svh"

package vchess_pkg;

   typedef logic [`PIECE_WIDTH-1:0]           piece_t;
   typedef logic [$clog2(`SQUARE_COUNT)-1:0]  square_t;   // Rank * 8 + file
   typedef piece_t [`SQUARE_COUNT-1:0]        board_t;    // Square n at index n
   typedef logic [`ADDR_WIDTH-1:0]            reg_addr_t;
   typedef logic [`DATA_WIDTH-1:0]            reg_data_t;
   typedef logic [`COUNTER_WIDTH-1:0]         counter_t;

   // One host transfer, held stable while req is high
   typedef struct packed {
      logic      write;
      reg_addr_t addr;
      reg_data_t data;
   } host_req_t;

   // Layout of the word read at the status address
   typedef struct packed {
      counter_t                              counter;
      logic [`DATA_WIDTH-`COUNTER_WIDTH-3:0] reserved;   // Always zero
      logic                                  mem_rst;    // Bit 1
      logic                                  calib_done; // Bit 0
   } status_t;

   typedef enum logic [1:0] {
      HS_IDLE,
      HS_ACK,             // Decode cycle, ack rises at its end
      HS_WAIT_RELEASE     // Ack held until req drops
   } hs_state_t;

endpackage

`default_nettype wire

/* include/vchess_config.svh */
`ifndef VCHESS_CONFIG_SVH
`define VCHESS_CONFIG_SVH

`define PIECE_WIDTH     4
`define SQUARE_COUNT    64
`define COUNTER_WIDTH   16
`define ADDR_WIDTH      8
`define DATA_WIDTH      32

`define REG_STATUS      8'h00   // Counter and synchronized flags
`define REG_RANDOM      8'h01   // Advances on every read
`define REG_LOAD        8'h02   // Bit 0, commit on rising edge
`define REG_SQUARE_BASE 8'h40   // a1 first, h8 at 0x7f

`define XORSHIFT_SEED   32'h2545_f491

`define EMPTY_POSN      4'd0
`define WHITE_PAWN      4'd1
`define WHITE_KNIT      4'd2
`define WHITE_BISH      4'd3
`define WHITE_ROOK      4'd4
`define WHITE_QUEN      4'd5
`define WHITE_KING      4'd6
`define BLACK_PAWN      4'd9    // Black codes are white plus 8
`define BLACK_KNIT      4'd10
`define BLACK_BISH      4'd11
`define BLACK_ROOK      4'd12
`define BLACK_QUEN      4'd13
`define BLACK_KING      4'd14

`endif
